//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_gmac_core
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- gmac_arp_cache.sv
`timescale 1ns/1ps

module gmac_arp_cache (
    input  logic               aximm_clk,
    input  gmac_pkg::arp_cmd_t arp_cmd,
    output gmac_pkg::word_t    arp_rd_data
);

    gmac_pkg::word_t mem [gmac_pkg::ARP_DEPTH];
    gmac_pkg::word_t rd_q;

    // Single write port driven by the register bank strobe
    always_ff @(posedge aximm_clk) begin
        if (arp_cmd.wr_en) begin
            mem[arp_cmd.wr_addr] <= arp_cmd.wr_data;
        end
    end

    // Read address sampled every cycle, one cycle of latency
    always_ff @(posedge aximm_clk) begin
        rd_q <= mem[arp_cmd.rd_addr];
    end

    assign arp_rd_data = rd_q;

endmodule

//--- gmac_core_checker.sv
`timescale 1ns/1ps

module gmac_core_checker (
    input logic aximm_clk,
    input logic gmac_reg_count_reset_we,
    input logic tx_valid,
    input logic tx_ready,
    input logic tx_eof,
    input logic out_valid,
    input logic out_ready,
    input logic core_enable
);

    int   fail_count = 0;
    logic frame_idle;
    logic frame_off;

    // Frame boundaries as the gate sees them
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            frame_idle <= 1'b1;
            frame_off  <= 1'b0;
        end else if (tx_valid && tx_ready && tx_eof) begin
            frame_idle <= 1'b1;
        end else if (frame_idle && tx_valid) begin
            frame_idle <= 1'b0;
            frame_off  <= !core_enable;
        end
    end

    a_valid_follows_input: assert property (@(posedge aximm_clk)
        disable iff (gmac_reg_count_reset_we) out_valid |-> tx_valid)
        else begin
            fail_count++;
            $error("out_valid high while tx_valid is low");
        end

    a_ready_passthrough: assert property (@(posedge aximm_clk)
        disable iff (gmac_reg_count_reset_we) out_valid |-> (tx_ready == out_ready))
        else begin
            fail_count++;
            $error("tx_ready differs from out_ready while forwarding");
        end

    a_quiet_after_reset: assert property (@(posedge aximm_clk)
        $fell(gmac_reg_count_reset_we) && !tx_valid |-> !out_valid && !tx_ready)
        else begin
            fail_count++;
            $error("stream outputs active right after reset");
        end

    // Frames started while disabled never reach the output
    a_no_output_when_off: assert property (@(posedge aximm_clk)
        disable iff (gmac_reg_count_reset_we)
        out_valid |-> (frame_idle ? core_enable : !frame_off))
        else begin
            fail_count++;
            $error("out_valid inside a frame that started while disabled");
        end

endmodule

bind gmac_core_top gmac_core_checker u_checker (
    .aximm_clk               (aximm_clk),
    .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
    .tx_valid                (tx_valid),
    .tx_ready                (tx_ready),
    .tx_eof                  (tx_in.eof),
    .out_valid               (out_valid),
    .out_ready               (out_ready),
    .core_enable             (core_enable)
);

//--- gmac_core_top.sv
`timescale 1ns/1ps

module gmac_core_top (
    input  logic                aximm_clk,
    input  logic                gmac_reg_count_reset_we,
    input  gmac_pkg::reg_wr_t   reg_wr,
    input  gmac_pkg::reg_addr_t reg_rd_addr,
    output gmac_pkg::word_t     reg_rd_data,
    input  gmac_pkg::tx_beat_t  tx_in,
    input  logic                tx_valid,
    output logic                tx_ready,
    output gmac_pkg::tx_beat_t  tx_out,
    output logic                out_valid,
    input  logic                out_ready
);

    gmac_pkg::tx_stats_t stats;
    gmac_pkg::word_t     arp_rd_data;
    gmac_pkg::arp_cmd_t  arp_cmd;
    gmac_pkg::tx_event_t tx_events;
    logic                core_enable;
    logic                window_tick;

    // Configuration and readback
    gmac_reg_bank u_reg_bank (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .reg_wr                  (reg_wr),
        .reg_rd_addr             (reg_rd_addr),
        .reg_rd_data             (reg_rd_data),
        .stats                   (stats),
        .arp_rd_data             (arp_rd_data),
        .arp_cmd                 (arp_cmd),
        .core_enable             (core_enable)
    );

    gmac_arp_cache u_arp_cache (
        .aximm_clk   (aximm_clk),
        .arp_cmd     (arp_cmd),
        .arp_rd_data (arp_rd_data)
    );

    // User stream gate towards the packer
    gmac_tx_frame_fsm u_tx_gate (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .core_enable             (core_enable),
        .tx_in                   (tx_in),
        .tx_valid                (tx_valid),
        .tx_ready                (tx_ready),
        .tx_out                  (tx_out),
        .out_valid               (out_valid),
        .out_ready               (out_ready),
        .tx_events               (tx_events)
    );

    gmac_rate_timer u_rate_timer (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .window_tick             (window_tick)
    );

    gmac_tx_stats u_tx_stats (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .tx_events               (tx_events),
        .window_tick             (window_tick),
        .stats                   (stats)
    );

endmodule

//--- gmac_pkg.sv
package gmac_pkg;

    // Basic widths
    localparam int ARP_ADDR_W = 4;
    localparam int ARP_DEPTH  = 16;

    typedef logic [31:0]           word_t;
    typedef logic [3:0]            reg_addr_t;
    typedef logic [ARP_ADDR_W-1:0] arp_addr_t;
    typedef logic [63:0]           stream_data_t;
    typedef logic [31:0]           ip_addr_t;
    typedef logic [15:0]           udp_port_t;

    // Register map
    localparam reg_addr_t ADDR_CORE_TYPE         = 4'h0;
    localparam reg_addr_t ADDR_MAC_H             = 4'h1;
    localparam reg_addr_t ADDR_MAC_L             = 4'h2;
    localparam reg_addr_t ADDR_LOCAL_IP          = 4'h3;
    localparam reg_addr_t ADDR_UDP_PORT          = 4'h4;
    localparam reg_addr_t ADDR_CORE_CTRL         = 4'h5;
    localparam reg_addr_t ADDR_ARP_WR_ADDR       = 4'h6;
    localparam reg_addr_t ADDR_ARP_WR_DATA       = 4'h7;
    localparam reg_addr_t ADDR_ARP_WR_EN         = 4'h8;
    localparam reg_addr_t ADDR_ARP_RD_ADDR       = 4'h9;
    localparam reg_addr_t ADDR_ARP_RD_DATA       = 4'hA;
    localparam reg_addr_t ADDR_TX_PKT_COUNT      = 4'hB;
    localparam reg_addr_t ADDR_TX_VALID_COUNT    = 4'hC;
    localparam reg_addr_t ADDR_TX_OVERFLOW_COUNT = 4'hD;
    localparam reg_addr_t ADDR_TX_PKT_RATE       = 4'hE;
    localparam reg_addr_t ADDR_TX_VALID_RATE     = 4'hF;

    // Identification and fabric defaults
    localparam word_t       CORE_TYPE   = 32'h0010_0064;
    localparam logic [47:0] FABRIC_MAC  = 48'h02_00_0a_0b_0c_0d;
    localparam ip_addr_t    FABRIC_IP   = 32'hc0a8_05c8;
    localparam udp_port_t   FABRIC_PORT = 16'h2710;

    // Rate measurement window in aximm_clk cycles
    localparam int RATE_WINDOW = 256;
    localparam int RATE_CNT_W  = $clog2(RATE_WINDOW);

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic      wr_en;
        arp_addr_t wr_addr;
        word_t     wr_data;
        arp_addr_t rd_addr;
    } arp_cmd_t;

    typedef struct packed {
        stream_data_t data;
        ip_addr_t     dest_ip;
        udp_port_t    dest_port;
        logic         eof;
    } tx_beat_t;

    typedef struct packed {
        logic word_done;
        logic frame_done;
        logic frame_dropped;
    } tx_event_t;

    typedef struct packed {
        word_t pkt_count;
        word_t valid_count;
        word_t overflow_count;
        word_t pkt_rate;
        word_t valid_rate;
    } tx_stats_t;

    typedef enum logic [1:0] {
        IDLE,
        PASS,
        DROP
    } fsm_state_t;

endpackage

//--- gmac_rate_timer.sv
`timescale 1ns/1ps

module gmac_rate_timer (
    input  logic aximm_clk,
    input  logic gmac_reg_count_reset_we,
    output logic window_tick
);

    logic [gmac_pkg::RATE_CNT_W-1:0] cnt;
    logic                            last;

    assign last = (cnt == gmac_pkg::RATE_CNT_W'(gmac_pkg::RATE_WINDOW - 1));

    // Free running, wraps at the end of each window
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            cnt <= '0;
        end else if (last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign window_tick = last;

endmodule

//--- gmac_reg_bank.sv
`timescale 1ns/1ps

module gmac_reg_bank (
    input  logic                aximm_clk,
    input  logic                gmac_reg_count_reset_we,
    input  gmac_pkg::reg_wr_t   reg_wr,
    input  gmac_pkg::reg_addr_t reg_rd_addr,
    output gmac_pkg::word_t     reg_rd_data,
    input  gmac_pkg::tx_stats_t stats,
    input  gmac_pkg::word_t     arp_rd_data,
    output gmac_pkg::arp_cmd_t  arp_cmd,
    output logic                core_enable
);

    gmac_pkg::word_t     mac_h;
    gmac_pkg::word_t     mac_l;
    gmac_pkg::ip_addr_t  local_ip;
    gmac_pkg::udp_port_t udp_port;
    gmac_pkg::word_t     core_ctrl;
    gmac_pkg::arp_addr_t arp_wr_addr;
    gmac_pkg::word_t     arp_wr_data;
    gmac_pkg::arp_addr_t arp_rd_addr;
    logic                arp_wr_pulse;

    // Write decode, one register per cycle
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            mac_h        <= gmac_pkg::word_t'(gmac_pkg::FABRIC_MAC[47:32]);
            mac_l        <= gmac_pkg::FABRIC_MAC[31:0];
            local_ip     <= gmac_pkg::FABRIC_IP;
            udp_port     <= gmac_pkg::FABRIC_PORT;
            core_ctrl    <= '0;
            arp_wr_addr  <= '0;
            arp_wr_data  <= '0;
            arp_rd_addr  <= '0;
            arp_wr_pulse <= 1'b0;
        end else begin
            arp_wr_pulse <= 1'b0;
            if (reg_wr.valid) begin
                unique case (reg_wr.addr)
                    gmac_pkg::ADDR_MAC_H:       mac_h       <= reg_wr.data;
                    gmac_pkg::ADDR_MAC_L:       mac_l       <= reg_wr.data;
                    gmac_pkg::ADDR_LOCAL_IP:    local_ip    <= reg_wr.data;
                    gmac_pkg::ADDR_UDP_PORT:    udp_port    <= reg_wr.data[15:0];
                    gmac_pkg::ADDR_CORE_CTRL:   core_ctrl   <= reg_wr.data;
                    gmac_pkg::ADDR_ARP_WR_ADDR:
                        arp_wr_addr <= reg_wr.data[gmac_pkg::ARP_ADDR_W-1:0];
                    gmac_pkg::ADDR_ARP_WR_DATA: arp_wr_data <= reg_wr.data;
                    // Strobe only, the cache takes the held address and data
                    gmac_pkg::ADDR_ARP_WR_EN:   arp_wr_pulse <= reg_wr.data[0];
                    gmac_pkg::ADDR_ARP_RD_ADDR:
                        arp_rd_addr <= reg_wr.data[gmac_pkg::ARP_ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign arp_cmd.wr_en   = arp_wr_pulse;
    assign arp_cmd.wr_addr = arp_wr_addr;
    assign arp_cmd.wr_data = arp_wr_data;
    assign arp_cmd.rd_addr = arp_rd_addr;

    assign core_enable = core_ctrl[0];

    // Read mux
    always_comb begin
        unique case (reg_rd_addr)
            gmac_pkg::ADDR_CORE_TYPE:         reg_rd_data = gmac_pkg::CORE_TYPE;
            gmac_pkg::ADDR_MAC_H:             reg_rd_data = mac_h;
            gmac_pkg::ADDR_MAC_L:             reg_rd_data = mac_l;
            gmac_pkg::ADDR_LOCAL_IP:          reg_rd_data = local_ip;
            gmac_pkg::ADDR_UDP_PORT:          reg_rd_data = gmac_pkg::word_t'(udp_port);
            gmac_pkg::ADDR_CORE_CTRL:         reg_rd_data = core_ctrl;
            gmac_pkg::ADDR_ARP_WR_ADDR:       reg_rd_data = gmac_pkg::word_t'(arp_wr_addr);
            gmac_pkg::ADDR_ARP_WR_DATA:       reg_rd_data = arp_wr_data;
            gmac_pkg::ADDR_ARP_WR_EN:         reg_rd_data = gmac_pkg::word_t'(arp_wr_pulse);
            gmac_pkg::ADDR_ARP_RD_ADDR:       reg_rd_data = gmac_pkg::word_t'(arp_rd_addr);
            gmac_pkg::ADDR_ARP_RD_DATA:       reg_rd_data = arp_rd_data;
            gmac_pkg::ADDR_TX_PKT_COUNT:      reg_rd_data = stats.pkt_count;
            gmac_pkg::ADDR_TX_VALID_COUNT:    reg_rd_data = stats.valid_count;
            gmac_pkg::ADDR_TX_OVERFLOW_COUNT: reg_rd_data = stats.overflow_count;
            gmac_pkg::ADDR_TX_PKT_RATE:       reg_rd_data = stats.pkt_rate;
            gmac_pkg::ADDR_TX_VALID_RATE:     reg_rd_data = stats.valid_rate;
            default:                          reg_rd_data = '0;
        endcase
    end

endmodule

//--- gmac_tx_frame_fsm.sv
`timescale 1ns/1ps

module gmac_tx_frame_fsm (
    input  logic                aximm_clk,
    input  logic                gmac_reg_count_reset_we,
    input  logic                core_enable,
    input  gmac_pkg::tx_beat_t  tx_in,
    input  logic                tx_valid,
    output logic                tx_ready,
    output gmac_pkg::tx_beat_t  tx_out,
    output logic                out_valid,
    input  logic                out_ready,
    output gmac_pkg::tx_event_t tx_events
);

    gmac_pkg::fsm_state_t state;
    gmac_pkg::fsm_state_t state_next;
    logic                 pass_mode;
    logic                 drop_mode;
    logic                 xfer;

    // In IDLE the enable bit decides the fate of the beat on offer
    always_comb begin
        pass_mode = (state == gmac_pkg::PASS) ||
                    ((state == gmac_pkg::IDLE) && core_enable);
        drop_mode = (state == gmac_pkg::DROP) ||
                    ((state == gmac_pkg::IDLE) && !core_enable);

        unique case (state)
            gmac_pkg::PASS: tx_ready = out_ready;
            gmac_pkg::DROP: tx_ready = 1'b1;
            default:        tx_ready = tx_valid && (core_enable ? out_ready : 1'b1);
        endcase

        xfer      = tx_valid && tx_ready;
        out_valid = pass_mode && tx_valid;
    end

    // Zero-latency forward path
    assign tx_out = tx_in;

    always_comb begin
        state_next = state;
        unique case (state)
            gmac_pkg::IDLE: begin
                // Lock the decision as soon as a beat is offered
                if (tx_valid && !(xfer && tx_in.eof)) begin
                    state_next = core_enable ? gmac_pkg::PASS : gmac_pkg::DROP;
                end
            end
            gmac_pkg::PASS,
            gmac_pkg::DROP: begin
                if (xfer && tx_in.eof) begin
                    state_next = gmac_pkg::IDLE;
                end
            end
            default: state_next = gmac_pkg::IDLE;
        endcase
    end

    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            state <= gmac_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Event pulses for the statistics block
    always_comb begin
        tx_events.word_done     = pass_mode && xfer;
        tx_events.frame_done    = pass_mode && xfer && tx_in.eof;
        tx_events.frame_dropped = drop_mode && xfer && tx_in.eof;
    end

endmodule

//--- gmac_tx_stats.sv
`timescale 1ns/1ps

module gmac_tx_stats (
    input  logic                aximm_clk,
    input  logic                gmac_reg_count_reset_we,
    input  gmac_pkg::tx_event_t tx_events,
    input  logic                window_tick,
    output gmac_pkg::tx_stats_t stats
);

    gmac_pkg::word_t pkt_count;
    gmac_pkg::word_t valid_count;
    gmac_pkg::word_t overflow_count;
    gmac_pkg::word_t pkt_rate;
    gmac_pkg::word_t valid_rate;
    gmac_pkg::word_t win_frames;
    gmac_pkg::word_t win_words;

    // Totals wrap silently
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            pkt_count      <= '0;
            valid_count    <= '0;
            overflow_count <= '0;
        end else begin
            pkt_count      <= pkt_count + gmac_pkg::word_t'(tx_events.frame_done);
            valid_count    <= valid_count + gmac_pkg::word_t'(tx_events.word_done);
            overflow_count <= overflow_count + gmac_pkg::word_t'(tx_events.frame_dropped);
        end
    end

    // Window accumulators, the tick cycle still counts toward the closing window
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            win_frames <= '0;
            win_words  <= '0;
            pkt_rate   <= '0;
            valid_rate <= '0;
        end else if (window_tick) begin
            pkt_rate   <= win_frames + gmac_pkg::word_t'(tx_events.frame_done);
            valid_rate <= win_words + gmac_pkg::word_t'(tx_events.word_done);
            win_frames <= '0;
            win_words  <= '0;
        end else begin
            win_frames <= win_frames + gmac_pkg::word_t'(tx_events.frame_done);
            win_words  <= win_words + gmac_pkg::word_t'(tx_events.word_done);
        end
    end

    assign stats.pkt_count      = pkt_count;
    assign stats.valid_count    = valid_count;
    assign stats.overflow_count = overflow_count;
    assign stats.pkt_rate       = pkt_rate;
    assign stats.valid_rate     = valid_rate;

endmodule

//--- sources.f
gmac_pkg.sv
gmac_reg_bank.sv
gmac_arp_cache.sv
gmac_tx_frame_fsm.sv
gmac_rate_timer.sv
gmac_tx_stats.sv
gmac_core_top.sv
gmac_core_checker.sv
tb_gmac_core.sv

//--- tb_gmac_core.sv
`timescale 1ns/1ps

module tb_gmac_core;

    localparam int LEN_REGS   = 100;
    localparam int LEN_ARP    = 300;
    localparam int LEN_STREAM = 400;
    localparam int LEN_RATES  = 3 * gmac_pkg::RATE_WINDOW + 100;
    localparam int MAX_CYCLES = LEN_REGS + LEN_ARP + LEN_STREAM + LEN_RATES + 2300;

    logic                aximm_clk;
    logic                gmac_reg_count_reset_we;
    gmac_pkg::reg_wr_t   reg_wr;
    gmac_pkg::reg_addr_t reg_rd_addr;
    gmac_pkg::word_t     reg_rd_data;
    gmac_pkg::tx_beat_t  tx_in;
    logic                tx_valid;
    logic                tx_ready;
    gmac_pkg::tx_beat_t  tx_out;
    logic                out_valid;
    logic                out_ready;

    logic [31:0] lfsr = 32'd7;
    int          cycles;
    int          checks;
    int          errors;
    int          tests;

    // Counter values expected from the traffic sent since the last reset
    gmac_pkg::word_t exp_pkts;
    gmac_pkg::word_t exp_words;
    gmac_pkg::word_t exp_drops;

    gmac_core_top u_dut (.*);

    initial begin
        aximm_clk = 1'b0;
        forever #4 aximm_clk = ~aximm_clk;
    end

    // Watchdog sized from the test lengths
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge aximm_clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic check_word(input string name, input gmac_pkg::word_t expected,
                              input gmac_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_beat(input string name, input gmac_pkg::tx_beat_t expected,
                              input gmac_pkg::tx_beat_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("Test %s done with %0d errors", name, errors - errors_before);
    endtask

    task automatic apply_reset();
        exp_pkts  = '0;
        exp_words = '0;
        exp_drops = '0;
        gmac_reg_count_reset_we = 1'b1;
        repeat (10) @(negedge aximm_clk);
        gmac_reg_count_reset_we = 1'b0;
    endtask

    // Tasks start and end on a falling edge
    task automatic write_reg(input gmac_pkg::reg_addr_t addr, input gmac_pkg::word_t data);
        reg_wr = '{valid: 1'b1, addr: addr, data: data};
        @(negedge aximm_clk);
        reg_wr.valid = 1'b0;
    endtask

    task automatic read_reg(input gmac_pkg::reg_addr_t addr, output gmac_pkg::word_t data);
        reg_rd_addr = addr;
        @(posedge aximm_clk);
        data = reg_rd_data;
        @(negedge aximm_clk);
    endtask

    task automatic expect_reg(input string name, input gmac_pkg::reg_addr_t addr,
                              input gmac_pkg::word_t expected);
        gmac_pkg::word_t value;
        read_reg(addr, value);
        check_word(name, expected, value);
    endtask

    // Frames of 1 to 8 beats; forwarded beats must come out in order
    task automatic send_frames(input string name, input int nf, input bit pass,
                               input bit stall, output int beats);
        gmac_pkg::tx_beat_t exp_q[$];
        gmac_pkg::tx_beat_t beat;
        int                 len;
        bit                 xfer;
        beats = 0;
        for (int f = 0; f < nf; f++) begin
            len = int'(rand_bits(3)) + 1;
            for (int b = 0; b < len; b++) begin
                beat.data      = gmac_pkg::stream_data_t'(rand_bits(64));
                beat.dest_ip   = gmac_pkg::ip_addr_t'(rand_bits(32));
                beat.dest_port = gmac_pkg::udp_port_t'(rand_bits(16));
                beat.eof       = (b == len - 1);
                if (pass) begin
                    exp_q.push_back(beat);
                end
                tx_in    = beat;
                tx_valid = 1'b1;
                do begin
                    out_ready = stall ? (rand_bits(2) != 0) : 1'b1;
                    @(posedge aximm_clk);
                    xfer = tx_valid && tx_ready;
                    if (out_valid && out_ready) begin
                        if (!pass || exp_q.size() == 0) begin
                            report_fault({name, ": output transfer with no beat expected"});
                        end else begin
                            check_beat(name, exp_q.pop_front(), tx_out);
                        end
                    end
                    if (pass && xfer && !(out_valid && out_ready)) begin
                        report_fault({name, ": input accepted but not forwarded"});
                    end
                    if (!pass && !tx_ready) begin
                        report_fault({name, ": discarded beat was not accepted"});
                    end
                    @(negedge aximm_clk);
                end while (!xfer);
                beats++;
            end
        end
        tx_valid  = 1'b0;
        out_ready = 1'b1;
        if (exp_q.size() != 0) begin
            report_fault({name, ": beats missing on the output"});
        end
    endtask

    task automatic test_regs();
        gmac_pkg::reg_addr_t a;
        gmac_pkg::word_t     w;
        int                  e0;
        e0 = errors;
        expect_reg("regs", gmac_pkg::ADDR_CORE_TYPE, gmac_pkg::CORE_TYPE);
        expect_reg("regs", gmac_pkg::ADDR_MAC_H, {16'h0, gmac_pkg::FABRIC_MAC[47:32]});
        expect_reg("regs", gmac_pkg::ADDR_MAC_L, gmac_pkg::FABRIC_MAC[31:0]);
        expect_reg("regs", gmac_pkg::ADDR_LOCAL_IP, gmac_pkg::FABRIC_IP);
        expect_reg("regs", gmac_pkg::ADDR_UDP_PORT, {16'h0, gmac_pkg::FABRIC_PORT});
        for (int i = 0; i < 5; i++) begin
            expect_reg("regs", gmac_pkg::ADDR_TX_PKT_COUNT + gmac_pkg::reg_addr_t'(i), '0);
        end
        for (a = gmac_pkg::ADDR_MAC_H; a <= gmac_pkg::ADDR_CORE_CTRL; a++) begin
            w = gmac_pkg::word_t'(rand_bits(32));
            write_reg(a, w);
            // UDP port holds 16 bits only
            if (a == gmac_pkg::ADDR_UDP_PORT) begin
                w = {16'h0, w[15:0]};
            end
            expect_reg("regs", a, w);
        end
        write_reg(gmac_pkg::ADDR_CORE_TYPE, gmac_pkg::word_t'(rand_bits(32)));
        expect_reg("regs", gmac_pkg::ADDR_CORE_TYPE, gmac_pkg::CORE_TYPE);
        write_reg(gmac_pkg::ADDR_TX_PKT_COUNT, 32'hffff_ffff);
        expect_reg("regs", gmac_pkg::ADDR_TX_PKT_COUNT, '0);
        finish_test("regs", e0);
    endtask

    task automatic test_arp();
        gmac_pkg::word_t entry [8];
        int              idx;
        int              e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            entry[i] = gmac_pkg::word_t'(rand_bits(32));
            write_reg(gmac_pkg::ADDR_ARP_WR_ADDR, gmac_pkg::word_t'(2 * i + 1));
            write_reg(gmac_pkg::ADDR_ARP_WR_DATA, entry[i]);
            write_reg(gmac_pkg::ADDR_ARP_WR_EN, 32'h1);
        end
        // Shuffled read order with one cycle each for address register and memory
        for (int i = 0; i < 8; i++) begin
            idx = (3 * i + 5) % 8;
            write_reg(gmac_pkg::ADDR_ARP_RD_ADDR, gmac_pkg::word_t'(2 * idx + 1));
            @(negedge aximm_clk);
            expect_reg("arp", gmac_pkg::ADDR_ARP_RD_DATA, entry[idx]);
        end
        finish_test("arp", e0);
    endtask

    task automatic test_forward();
        int beats;
        int e0;
        e0 = errors;
        write_reg(gmac_pkg::ADDR_CORE_CTRL, 32'h1);
        send_frames("forward", 6, 1'b1, 1'b1, beats);
        exp_pkts  = exp_pkts + 32'd6;
        exp_words = exp_words + gmac_pkg::word_t'(beats);
        expect_reg("forward", gmac_pkg::ADDR_TX_PKT_COUNT, exp_pkts);
        expect_reg("forward", gmac_pkg::ADDR_TX_VALID_COUNT, exp_words);
        finish_test("forward", e0);
    endtask

    task automatic test_drop();
        int beats;
        int e0;
        e0 = errors;
        write_reg(gmac_pkg::ADDR_CORE_CTRL, 32'h0);
        send_frames("drop", 4, 1'b0, 1'b1, beats);
        exp_drops = exp_drops + 32'd4;
        expect_reg("drop", gmac_pkg::ADDR_TX_OVERFLOW_COUNT, exp_drops);
        write_reg(gmac_pkg::ADDR_CORE_CTRL, 32'h1);
        send_frames("drop", 1, 1'b1, 1'b0, beats);
        exp_pkts  = exp_pkts + 32'd1;
        exp_words = exp_words + gmac_pkg::word_t'(beats);
        expect_reg("drop", gmac_pkg::ADDR_TX_PKT_COUNT, exp_pkts);
        expect_reg("drop", gmac_pkg::ADDR_TX_VALID_COUNT, exp_words);
        finish_test("drop", e0);
    endtask

    task automatic test_rates();
        int beats;
        int e0;
        e0 = errors;
        apply_reset();
        write_reg(gmac_pkg::ADDR_CORE_CTRL, 32'h1);
        send_frames("rates", 3, 1'b1, 1'b0, beats);
        repeat (gmac_pkg::RATE_WINDOW) @(negedge aximm_clk);
        expect_reg("rates", gmac_pkg::ADDR_TX_PKT_RATE, 32'd3);
        expect_reg("rates", gmac_pkg::ADDR_TX_VALID_RATE, gmac_pkg::word_t'(beats));
        // One idle window
        repeat (gmac_pkg::RATE_WINDOW) @(negedge aximm_clk);
        expect_reg("rates", gmac_pkg::ADDR_TX_PKT_RATE, '0);
        expect_reg("rates", gmac_pkg::ADDR_TX_VALID_RATE, '0);
        finish_test("rates", e0);
    endtask

    initial begin
        gmac_reg_count_reset_we = 1'b1;
        reg_wr      = '0;
        reg_rd_addr = '0;
        tx_in       = '0;
        tx_valid    = 1'b0;
        out_ready   = 1'b1;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        @(negedge aximm_clk);
        apply_reset();
        test_regs();
        test_arp();
        test_forward();
        test_drop();
        test_rates();
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, u_dut.u_checker.fail_count);
        if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
